// File: verilog/dataOutputPkg.sv
package dataOutputPkg;

    // write beat and DQ bus width
    localparam int DataWidth = 16;

    // bytes added to the byte count per accepted beat
    localparam int BytesPerBeat = 2;

    // chip-enable copies and the width of each pin-control field
    localparam int ChannelCount = 2;

    localparam int ByteCountWidth = 16; // byte count and byte counter

    // sequencer states
    typedef enum logic [2:0] {
        Idle,
        Latch,       // command captured, way selected
        WaitDqss,    // tDQSS setup
        Transfer,    // write ready high
        AwaitBeat,   // waiting on the source
        Postamble    // tWPST before last step
    } burstState_t;

    // one DQ bus word with its strobe pair
    typedef struct packed {
        logic [DataWidth/8-1:0] strobe;
        logic [DataWidth-1:0]   dq;
    } dqWord_t;

    // NAND pin controls with one bit per channel
    typedef struct packed {
        logic [ChannelCount-1:0] writeEnable;
        logic [ChannelCount-1:0] addressLatchEnable;
        logic [ChannelCount-1:0] commandLatchEnable;
    } nandPinCtrl_t;

endpackage

// File: verilog/burstSequencer.sv
`timescale 1ns/1ps

module burstSequencer #(
    parameter int NumberOfWays = 4,
    parameter int TdqssCycles  = 3,
    parameter int TwpstCycles  = 6
) (
    input  logic                                                iSystemClock,
    input  logic                                                iReset,
    input  logic                                                iStart,
    input  logic [NumberOfWays-1:0]                             iTargetWay,
    input  logic [dataOutputPkg::ByteCountWidth-1:0]            iNumOfData,
    input  logic [dataOutputPkg::DataWidth-1:0]                 iWriteData,
    input  logic                                                iWriteValid,
    output logic                                                oReady,
    output logic                                                oLastStep,
    output logic                                                oWriteReady,
    output logic                                                beatAccept,
    output logic [dataOutputPkg::DataWidth-1:0]                 beatData,
    output logic [dataOutputPkg::ChannelCount*NumberOfWays-1:0] oChipEnable,
    output dataOutputPkg::nandPinCtrl_t                         oPinCtrl
);
    import dataOutputPkg::*;

    localparam int LongestWait = (TdqssCycles > TwpstCycles) ? TdqssCycles : TwpstCycles;
    // counter reaches TwpstCycles+1 while last step is high
    localparam int TimerWidth  = $clog2(LongestWait + 2);

    burstState_t               state;
    burstState_t               nextState;

    logic [ByteCountWidth-1:0] numOfData;
    logic [ByteCountWidth-1:0] byteCount;
    logic [ByteCountWidth:0]   nextByteCount;
    logic [TimerWidth-1:0]     timeCounter;

    logic                      startCommand;
    logic                      finalBeat;
    logic                      dqssDone;
    logic                      wpstDone;
    logic                      timedState;

    assign startCommand = iStart & oReady; // start ignored while busy
    assign beatAccept   = iWriteValid & oWriteReady;
    assign beatData     = iWriteData;

    // one extra bit so the last increment cannot wrap
    assign nextByteCount = {1'b0, byteCount} + (ByteCountWidth + 1)'(BytesPerBeat);
    assign finalBeat     = nextByteCount >= {1'b0, numOfData};

    assign dqssDone   = timeCounter == TimerWidth'(TdqssCycles - 1);
    assign wpstDone   = timeCounter == TimerWidth'(TwpstCycles);
    assign timedState = (state == WaitDqss) || (state == Postamble);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (startCommand) begin
                    nextState = Latch;
                end
            end
            Latch: begin
                nextState = WaitDqss;
            end
            WaitDqss: begin
                if (dqssDone) begin
                    nextState = AwaitBeat;
                end
            end
            AwaitBeat: begin
                if (iWriteValid) begin
                    nextState = Transfer;
                end
            end
            Transfer: begin
                if (!beatAccept) begin
                    nextState = AwaitBeat; // source went quiet
                end else if (finalBeat) begin
                    nextState = Postamble;
                end
            end
            Postamble: begin
                if (oLastStep) begin
                    nextState = Idle;
                end
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    // shared by tDQSS and tWPST and cleared on every state change
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            timeCounter <= '0;
        end else if (timedState && (nextState == state)) begin
            timeCounter <= timeCounter + 1'b1;
        end else begin
            timeCounter <= '0;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            byteCount <= '0;
        end else if (startCommand) begin
            byteCount <= '0;
        end else if (beatAccept) begin
            byteCount <= nextByteCount[ByteCountWidth-1:0];
        end
    end

    // total taken on the start edge and held for the whole command
    always_ff @(posedge iSystemClock) begin
        if (startCommand) begin
            numOfData <= iNumOfData;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oReady      <= 1'b0;
            oWriteReady <= 1'b0;
            oLastStep   <= 1'b0;
        end else begin
            oReady      <= nextState == Idle;
            oWriteReady <= nextState == Transfer; // stays up while valid stays up
            oLastStep   <= (state == Postamble) && wpstDone;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oChipEnable <= '0;
        end else if (startCommand) begin
            oChipEnable <= {ChannelCount{iTargetWay}}; // same way on both channels
        end else if (nextState == Idle) begin
            oChipEnable <= '0;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oPinCtrl <= '0;
        end else begin
            oPinCtrl.writeEnable        <= ChannelCount'(1);
            // latch enables mark the cycle after each accepted beat
            oPinCtrl.addressLatchEnable <= {ChannelCount{beatAccept}};
            oPinCtrl.commandLatchEnable <= {ChannelCount{beatAccept}};
        end
    end

endmodule

// File: verilog/dqOutputPipeline.sv
`timescale 1ns/1ps

module dqOutputPipeline #(
    parameter int OutputDelay = 2
) (
    input  logic                                iSystemClock,
    input  logic                                iReset,
    input  logic                                beatAccept,
    input  logic [dataOutputPkg::DataWidth-1:0] beatData,
    output dataOutputPkg::dqWord_t              oDqWord
);
    import dataOutputPkg::*;

    localparam int HalfWidth = DataWidth / 2;

    dqWord_t formattedWord;

    // stage 0 is the format register and the rest make up the output delay
    dqWord_t delayLine [0:OutputDelay];

    // byte swap with the strobe pair only on accepted beats
    always_comb begin
        formattedWord = '0;
        if (beatAccept) begin
            formattedWord.strobe = '1;
            formattedWord.dq     = {beatData[HalfWidth-1:0], beatData[DataWidth-1:HalfWidth]};
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            for (int i = 0; i <= OutputDelay; i++) begin
                delayLine[i] <= '0;
            end
        end else begin
            delayLine[0] <= formattedWord;
            for (int i = 1; i <= OutputDelay; i++) begin
                delayLine[i] <= delayLine[i-1]; // idle cycles shift zeros
            end
        end
    end

    assign oDqWord = delayLine[OutputDelay];

endmodule

// File: verilog/dataOutputSync.sv
`timescale 1ns/1ps

module dataOutputSync #(
    parameter int NumberOfWays = 4,
    parameter int TdqssCycles  = 3,
    parameter int TwpstCycles  = 6,
    parameter int OutputDelay  = 2
) (
    input  logic                                                iSystemClock,
    input  logic                                                iReset,
    input  logic                                                iStart,
    input  logic [NumberOfWays-1:0]                             iTargetWay,
    input  logic [dataOutputPkg::ByteCountWidth-1:0]            iNumOfData,
    input  logic [dataOutputPkg::DataWidth-1:0]                 iWriteData,
    input  logic                                                iWriteValid,
    output logic                                                oReady,
    output logic                                                oLastStep,
    output logic                                                oWriteReady,
    output dataOutputPkg::dqWord_t                              oDqWord,
    output logic [dataOutputPkg::ChannelCount*NumberOfWays-1:0] oChipEnable,
    output dataOutputPkg::nandPinCtrl_t                         oPinCtrl
);
    import dataOutputPkg::*;

    logic                 beatAccept;
    logic [DataWidth-1:0] beatData;   // beat taken on the beatAccept edge

    burstSequencer #(
        .NumberOfWays (NumberOfWays),
        .TdqssCycles  (TdqssCycles),
        .TwpstCycles  (TwpstCycles)
    ) sequencer (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .iWriteData   (iWriteData),
        .iWriteValid  (iWriteValid),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oWriteReady  (oWriteReady),
        .beatAccept   (beatAccept),
        .beatData     (beatData),
        .oChipEnable  (oChipEnable),
        .oPinCtrl     (oPinCtrl)
    );

    // OutputDelay+1 cycles from acceptance to the DQ pins
    dqOutputPipeline #(
        .OutputDelay  (OutputDelay)
    ) pipeline (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .beatAccept   (beatAccept),
        .beatData     (beatData),
        .oDqWord      (oDqWord)
    );

endmodule

// File: dv/dataOutputSyncAsserts.sv
`timescale 1ns/1ps

module dataOutputSyncAsserts #(
    parameter int OutputDelay = 2
) (
    input logic                                  iSystemClock,
    input logic                                  iReset,
    input logic                                  beatAccept,
    input logic [dataOutputPkg::DataWidth/8-1:0] strobe,
    input logic                                  oReady,
    input logic                                  oWriteReady,
    input logic                                  oLastStep
);

    // a beat reaches the pins OutputDelay+1 edges after acceptance
    strobeFollowsAccept: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        strobe == ($past(beatAccept, OutputDelay + 1) ? 2'b11 : 2'b00)
    ) else $error("strobe does not match the acceptance %0d edges earlier", OutputDelay + 1);

    lastStepOneCycle: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        oLastStep |=> !oLastStep
    ) else $error("last step held for more than one cycle");

    readyAfterLastStep: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        oLastStep |=> oReady
    ) else $error("ready did not return after last step");

    noWriteWhileIdle: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        !(oWriteReady && oReady)
    ) else $error("write ready high while command ready is high");

endmodule

bind dataOutputSync dataOutputSyncAsserts #(
    .OutputDelay  (OutputDelay)
) asserts (
    .iSystemClock (iSystemClock),
    .iReset       (iReset),
    .beatAccept   (beatAccept),
    .strobe       (oDqWord.strobe),
    .oReady       (oReady),
    .oWriteReady  (oWriteReady),
    .oLastStep    (oLastStep)
);

// File: dv/dataOutputSyncTb.sv
`timescale 1ns/1ps

module dataOutputSyncTb;
    import dataOutputPkg::*;

    localparam int NumberOfWays = 4;
    localparam int TdqssCycles  = 3;
    localparam int TwpstCycles  = 6;
    localparam int OutputDelay  = 2;
    localparam int EnableWidth  = ChannelCount * NumberOfWays;

    localparam logic [31:0] Seed = 32'd54;
    localparam int NumCommands    = 8;
    localparam int CyclesPerByte  = 6;
    localparam int WatchdogMargin = 400; // covers tDQSS, tWPST and handshakes per command

    typedef enum logic [1:0] {
        Continuous,        // valid also held past the last beat
        RandomGaps,
        GapsWithStrayStart // plus iStart while busy
    } gapMode_t;

    typedef struct packed {
        logic [NumberOfWays-1:0]   way;
        logic [ByteCountWidth-1:0] byteCount;
        gapMode_t                  gapMode;
    } stimulus_t;

    stimulus_t stimulusTable [NumCommands] = '{
        '{4'b0001, 16'd2,  Continuous},
        '{4'b0010, 16'd16, Continuous},
        '{4'b0100, 16'd12, RandomGaps},
        '{4'b1000, 16'd32, RandomGaps},
        '{4'b0001, 16'd8,  GapsWithStrayStart},
        '{4'b0100, 16'd40, Continuous},
        '{4'b1000, 16'd20, GapsWithStrayStart},
        '{4'b0010, 16'd26, RandomGaps}
    };

    logic                      iSystemClock;
    logic                      iReset;
    logic                      iStart;
    logic [NumberOfWays-1:0]   iTargetWay;
    logic [ByteCountWidth-1:0] iNumOfData;
    logic [DataWidth-1:0]      iWriteData;
    logic                      iWriteValid;
    logic                      oReady;
    logic                      oLastStep;
    logic                      oWriteReady;
    dqWord_t                   oDqWord;
    logic [EnableWidth-1:0]    oChipEnable;
    nandPinCtrl_t              oPinCtrl;

    logic [31:0]          lcgState = Seed;
    int                   cycleCount = 0;   // rising edges so far
    logic                 monitorOn = 1'b0;
    logic                 sawAccept = 1'b0;
    int                   acceptTotal = 0;
    logic [DataWidth-1:0] expectedWords [$];
    int                   acceptEdges [$];
    logic [DataWidth-1:0] expectedWord;
    int                   acceptEdge;

    dataOutputSync #(
        .NumberOfWays (NumberOfWays),
        .TdqssCycles  (TdqssCycles),
        .TwpstCycles  (TwpstCycles),
        .OutputDelay  (OutputDelay)
    ) dut (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .iWriteData   (iWriteData),
        .iWriteValid  (iWriteValid),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oWriteReady  (oWriteReady),
        .oDqWord      (oDqWord),
        .oChipEnable  (oChipEnable),
        .oPinCtrl     (oPinCtrl)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #10 iSystemClock = ~iSystemClock;
    end

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic int watchdogBudget();
        int cycles;
        cycles = WatchdogMargin;
        for (int i = 0; i < NumCommands; i++) begin
            cycles += int'(stimulusTable[i].byteCount) * CyclesPerByte;
        end
        return cycles;
    endfunction

    task automatic stopOnFailure();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkIdleOutputs();
        checkValue(32'(oReady), 32'd1, "ready while idle");
        checkValue(32'(oChipEnable), 32'd0, "chip enable while idle");
        checkValue(32'(oWriteReady), 32'd0, "write ready while idle");
        checkValue(32'(oLastStep), 32'd0, "last step while idle");
    endtask

    task automatic checkBusyOutputs(input logic [EnableWidth-1:0] expectedEnable,
                                    input int startEdge);
        checkValue(32'(oReady), 32'd0, "ready while busy");
        checkValue(32'(oChipEnable), 32'(expectedEnable), "chip enable while busy");
        if (oWriteReady) begin
            checkValue(32'(cycleCount >= startEdge + TdqssCycles + 2), 32'd1,
                       "write ready before tDQSS elapsed");
        end
    endtask

    task automatic runCommand(input stimulus_t entry);
        logic [EnableWidth-1:0] expectedEnable;
        logic [31:0]            randomWord;
        int                     beatCount;
        int                     acceptsBefore;
        int                     startEdge;
        int                     finalEdge;
        int                     gap;
        logic                   accepted;

        beatCount      = int'(entry.byteCount) / BytesPerBeat;
        expectedEnable = {ChannelCount{entry.way}};
        acceptsBefore  = acceptTotal;
        finalEdge      = 0;

        do begin
            @(negedge iSystemClock);
        end while (!oReady);
        @(posedge iSystemClock);
        iStart     <= 1'b1;
        iTargetWay <= entry.way;
        iNumOfData <= entry.byteCount;
        @(posedge iSystemClock); // command taken here
        if (entry.gapMode == GapsWithStrayStart) begin
            iTargetWay <= ~entry.way; // busy now so this start must be ignored
            iNumOfData <= entry.byteCount + 16'd8;
        end else begin
            iStart <= 1'b0;
        end
        @(negedge iSystemClock);
        startEdge = cycleCount;
        checkBusyOutputs(expectedEnable, startEdge);
        @(posedge iSystemClock);
        iStart <= 1'b0;

        for (int beat = 0; beat < beatCount; beat++) begin
            randomWord = nextRandom();
            gap = (entry.gapMode == Continuous) ? 0 : int'(randomWord[30:29]);
            if (gap > 0) begin
                iWriteValid <= 1'b0;
                repeat (gap) begin
                    @(negedge iSystemClock);
                    checkBusyOutputs(expectedEnable, startEdge);
                    @(posedge iSystemClock);
                end
            end
            iWriteValid <= 1'b1;
            iWriteData  <= randomWord[23:8];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge iSystemClock);
                checkBusyOutputs(expectedEnable, startEdge);
                accepted  = iWriteValid && oWriteReady;
                finalEdge = cycleCount + 1;
                @(posedge iSystemClock);
            end
        end

        // continuous source keeps offering a beat past the count
        if (entry.gapMode == Continuous) begin
            randomWord = nextRandom();
            iWriteData <= randomWord[23:8];
        end else begin
            iWriteValid <= 1'b0;
        end
        do begin
            @(negedge iSystemClock);
            checkBusyOutputs(expectedEnable, startEdge);
        end while (!oLastStep);
        checkValue(32'(cycleCount), 32'(finalEdge + TwpstCycles + 1), "last step timing");
        @(posedge iSystemClock);
        iWriteValid <= 1'b0;
        @(negedge iSystemClock);
        checkIdleOutputs();
        checkValue(32'(acceptTotal - acceptsBefore), 32'(beatCount), "accepted beat count");
    endtask

    // scoreboard and pin checks sampled mid-cycle
    always @(negedge iSystemClock) begin
        if (monitorOn) begin
            checkValue(32'(oPinCtrl.writeEnable), 32'd1, "write enable");
            checkValue(32'(oPinCtrl.addressLatchEnable), 32'({ChannelCount{sawAccept}}),
                       "address latch enable");
            checkValue(32'(oPinCtrl.commandLatchEnable), 32'({ChannelCount{sawAccept}}),
                       "command latch enable");
            if (oDqWord.strobe != '0) begin
                checkValue(32'(oDqWord.strobe), 32'h3, "strobe pair");
                if (expectedWords.size() == 0) begin
                    $display("strobed word on the DQ bus with no accepted beat pending");
                    stopOnFailure();
                end else begin
                    expectedWord = expectedWords.pop_front();
                    acceptEdge   = acceptEdges.pop_front();
                    checkValue(32'(oDqWord.dq), 32'(expectedWord), "dq word");
                    checkValue(32'(cycleCount), 32'(acceptEdge + OutputDelay), "dq word timing");
                end
            end else begin
                checkValue(32'(oDqWord.dq), 32'd0, "dq without strobe");
            end
            sawAccept = iWriteValid && oWriteReady;
            if (sawAccept) begin
                // low byte goes out on the upper half
                expectedWords.push_back({iWriteData[7:0], iWriteData[15:8]});
                acceptEdges.push_back(cycleCount + 1);
                acceptTotal++;
            end
        end
    end

    initial begin
        repeat (watchdogBudget()) @(posedge iSystemClock);
        $display("watchdog expired before all commands completed");
        stopOnFailure();
    end

    initial begin
        iReset      = 1'b1;
        iStart      = 1'b0;
        iTargetWay  = '0;
        iNumOfData  = '0;
        iWriteData  = '0;
        iWriteValid = 1'b0;
        repeat (4) @(posedge iSystemClock);
        iReset <= 1'b0;
        @(negedge iSystemClock);
        checkValue(32'(oReady), 32'd0, "ready in reset");
        checkValue(32'({oLastStep, oWriteReady}), 32'd0, "handshake in reset");
        checkValue(32'(oPinCtrl), 32'd0, "pin control in reset");
        checkValue(32'(oDqWord), 32'd0, "dq word in reset");
        checkValue(32'(oChipEnable), 32'd0, "chip enable in reset");
        @(negedge iSystemClock);
        checkIdleOutputs();
        checkValue(32'(oPinCtrl.writeEnable), 32'd1, "first idle write enable");
        checkValue(32'(oPinCtrl.addressLatchEnable), 32'd0, "first idle address latch");
        checkValue(32'(oPinCtrl.commandLatchEnable), 32'd0, "first idle command latch");
        checkValue(32'(oDqWord), 32'd0, "first idle dq word");
        @(posedge iSystemClock);
        monitorOn = 1'b1;

        for (int i = 0; i < NumCommands; i++) begin
            runCommand(stimulusTable[i]);
        end

        repeat (8) begin
            @(negedge iSystemClock);
            checkIdleOutputs();
        end
        if (expectedWords.size() != 0) begin
            $display("accepted beats never reached the DQ bus");
            stopOnFailure();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: dataOutputSync.f
verilog/dataOutputPkg.sv
verilog/burstSequencer.sv
verilog/dqOutputPipeline.sv
verilog/dataOutputSync.sv
dv/dataOutputSyncAsserts.sv
dv/dataOutputSyncTb.sv

// File: Makefile
TOP := dataOutputSyncTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f dataOutputSync.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir \
		-f dataOutputSync.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
